// File: source/mems_scan_pkg.sv
`default_nettype none

package mems_scan_pkg;

  // apb register offsets
  localparam logic [7:0] ADDR_CTRL     = 8'h00;
  localparam logic [7:0] ADDR_FAST_LIM = 8'h04;
  localparam logic [7:0] ADDR_SLOW_LIM = 8'h08;
  localparam logic [7:0] ADDR_STATUS   = 8'h0C;

  // dac command codes
  localparam logic [2:0] CMD_SOFT_RESET   = 3'b101;
  localparam logic [2:0] CMD_LDAC_SETUP   = 3'b110;
  localparam logic [2:0] CMD_WRITE_UPDATE = 3'b011;
  localparam logic [2:0] CMD_INT_REF      = 3'b111;

  localparam logic [15:0] SOFT_RESET_SETTING = 16'h0001;
  localparam logic [15:0] LDAC_SETTING       = 16'h000F; // ldac inactive on all four channels
  localparam logic [15:0] INT_REF_SETTING    = 16'h0001;

  // scan limits out of reset
  localparam logic [7:0] FAST_DOWN_RESET = 8'd34;
  localparam logic [7:0] FAST_UP_RESET   = 8'd154;
  localparam logic [7:0] SLOW_DOWN_RESET = 8'd34;
  localparam logic [7:0] SLOW_UP_RESET   = 8'd154;

  localparam logic [7:0] SPI_DIV       = 8'd2;  // clk cycles per sclk half period
  localparam logic [5:0] SPI_LAST_HALF = 6'd47; // 24 bits, two halves each

  // sequencer outer states
  localparam logic [1:0] ST_IDLE       = 2'd0;
  localparam logic [1:0] ST_SOFT_RESET = 2'd1;
  localparam logic [1:0] ST_LDAC_SETUP = 2'd2;
  localparam logic [1:0] ST_SCAN       = 2'd3;

  // sequencer inner states, A to D double as dac channel address
  localparam logic [2:0] CH_A   = 3'd0;
  localparam logic [2:0] CH_B   = 3'd1;
  localparam logic [2:0] CH_C   = 3'd2;
  localparam logic [2:0] CH_D   = 3'd3;
  localparam logic [2:0] CH_REF = 3'd4;

  // one 24-bit dac frame, either a channel write or a control command
  typedef union packed {
    struct packed {
      logic [1:0] dc;
      logic [2:0] cmd;
      logic [2:0] addr;
      logic [7:0] level;
      logic [7:0] pad; // low byte unused by an 8-bit dac
    } chan;
    struct packed {
      logic [1:0]  dc;
      logic [2:0]  cmd;
      logic [2:0]  addr;
      logic [15:0] setting;
    } ctrl;
  } dac_word_u;

endpackage

`default_nettype wire

// File: source/mems_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mems_apb_regs (
  input  logic        clk,
  input  logic        mems_soft_reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  input  logic        new_line,
  input  logic        new_frame,
  input  logic        spi_busy,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        enable,
  output logic        pause,
  output logic [7:0]  fast_down,
  output logic [7:0]  fast_up,
  output logic [7:0]  slow_down,
  output logic [7:0]  slow_up
);
  import mems_scan_pkg::*;

  logic access;
  logic wr_en;
  logic mapped;

  assign access = psel && penable;
  assign wr_en  = access && pwrite && mapped && (paddr != ADDR_STATUS);
  assign pready = 1'b1; // no wait states

  assign mapped = (paddr == ADDR_CTRL) || (paddr == ADDR_FAST_LIM) ||
                  (paddr == ADDR_SLOW_LIM) || (paddr == ADDR_STATUS);

  // status is read only
  assign pslverr = access && (!mapped || (pwrite && (paddr == ADDR_STATUS)));

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      enable    <= 1'b0;
      pause     <= 1'b0;
      fast_down <= FAST_DOWN_RESET;
      fast_up   <= FAST_UP_RESET;
      slow_down <= SLOW_DOWN_RESET;
      slow_up   <= SLOW_UP_RESET;
    end else if (wr_en) begin
      case (paddr)
        ADDR_CTRL: begin
          enable <= pwdata[0];
          pause  <= pwdata[1];
        end
        ADDR_FAST_LIM: begin
          fast_down <= pwdata[7:0];
          fast_up   <= pwdata[15:8];
        end
        ADDR_SLOW_LIM: begin
          slow_down <= pwdata[7:0];
          slow_up   <= pwdata[15:8];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    prdata = 32'd0;
    if (psel && !pwrite) begin
      case (paddr)
        ADDR_CTRL:     prdata = {30'd0, pause, enable};
        ADDR_FAST_LIM: prdata = {16'd0, fast_up, fast_down};
        ADDR_SLOW_LIM: prdata = {16'd0, slow_up, slow_down};
        ADDR_STATUS:   prdata = {29'd0, spi_busy, new_frame, new_line}; // live flags
        default:       prdata = 32'd0;
      endcase
    end
  end

  // every access phase follows a setup phase
  a_apb_phase: assert property (@(posedge clk) disable iff (mems_soft_reset)
    penable |-> psel && $past(psel && !penable));

endmodule

`default_nettype wire

// File: source/fast_axis_ramp.sv
`timescale 1ns/1ps
`default_nettype none

module fast_axis_ramp (
  input  logic       clk,
  input  logic       mems_soft_reset,
  input  logic       step,
  input  logic [7:0] down_limit,
  input  logic [7:0] up_limit,
  output logic [7:0] level_a,
  output logic [7:0] level_b,
  output logic       line_wrap
);
  import mems_scan_pkg::*;

  logic [7:0] level_a_q;
  logic       past_up;

  // A runs from down to up+1 before it reloads
  assign past_up = level_a_q > up_limit;

  assign line_wrap = step && past_up; // same cycle as the step
  assign level_a   = level_a_q;

  // mirror of A around the centre of the band
  assign level_b = down_limit + up_limit - level_a_q;

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      level_a_q <= FAST_DOWN_RESET;
    end else if (step) begin
      if (past_up) begin
        level_a_q <= down_limit; // start of next line
      end else begin
        level_a_q <= level_a_q + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/slow_axis_ramp.sv
`timescale 1ns/1ps
`default_nettype none

module slow_axis_ramp (
  input  logic       clk,
  input  logic       mems_soft_reset,
  input  logic       step,
  input  logic [7:0] down_limit,
  input  logic [7:0] up_limit,
  output logic [7:0] level_c,
  output logic [7:0] level_d,
  output logic       frame_wrap
);
  import mems_scan_pkg::*;

  logic [7:0] level_c_q;
  logic       past_up;

  assign past_up = level_c_q > up_limit;

  // step is the line wrap, so a frame wrap lands on the same cycle
  assign frame_wrap = step && past_up;
  assign level_c    = level_c_q;
  assign level_d    = down_limit + up_limit - level_c_q; // mirrored C

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      level_c_q <= SLOW_DOWN_RESET;
    end else if (step) begin
      if (past_up) begin
        level_c_q <= down_limit;
      end else begin
        level_c_q <= level_c_q + 8'd1; // one step per line
      end
    end
  end

  // line wrap arrives as a single-cycle pulse
  a_step_pulse: assert property (@(posedge clk) disable iff (mems_soft_reset)
    step |=> !step);

endmodule

`default_nettype wire

// File: source/dac_frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dac_frame_sequencer (
  input  logic        clk,
  input  logic        mems_soft_reset,
  input  logic        enable,
  input  logic        pause,
  input  logic        spi_busy,
  input  logic [7:0]  level_a,
  input  logic [7:0]  level_b,
  input  logic [7:0]  level_c,
  input  logic [7:0]  level_d,
  input  logic        line_wrap,
  input  logic        frame_wrap,
  input  logic        new_line_fifo_done,
  input  logic        new_frame_fifo_done,
  output logic        fast_step,
  output logic        spi_start,
  output logic [23:0] spi_word,
  output logic        new_line,
  output logic        new_frame
);
  import mems_scan_pkg::*;

  logic [1:0] state_q, state_d;
  logic [2:0] ch_q, ch_d;
  logic       start_q;
  logic       can_issue;
  logic       issue;
  logic [7:0] chan_level;
  logic [7:0] lvl_b_q, lvl_c_q, lvl_d_q; // point snapshot taken with A
  logic [23:0] word_q;
  logic       new_line_q, new_frame_q;
  dac_word_u  word_d;

  // busy only rises the cycle after a start
  assign can_issue = !spi_busy && !start_q;

  always_comb begin
    case (ch_q)
      CH_A:    chan_level = level_a;
      CH_B:    chan_level = lvl_b_q;
      CH_C:    chan_level = lvl_c_q;
      default: chan_level = lvl_d_q;
    endcase
  end

  always_comb begin
    state_d   = state_q;
    ch_d      = ch_q;
    issue     = 1'b0;
    fast_step = 1'b0;
    word_d    = '0;
    case (state_q)
      ST_IDLE: begin
        if (enable) state_d = ST_SOFT_RESET;
      end
      ST_SOFT_RESET: begin
        if (!enable) begin
          state_d = ST_IDLE;
        end else if (can_issue) begin
          issue               = 1'b1;
          word_d.ctrl.cmd     = CMD_SOFT_RESET;
          word_d.ctrl.setting = SOFT_RESET_SETTING;
          state_d             = ST_LDAC_SETUP;
        end
      end
      ST_LDAC_SETUP: begin
        if (!enable) begin
          state_d = ST_IDLE;
        end else if (can_issue) begin
          issue               = 1'b1;
          word_d.ctrl.cmd     = CMD_LDAC_SETUP;
          word_d.ctrl.setting = LDAC_SETTING;
          state_d             = ST_SCAN;
          ch_d                = CH_A;
        end
      end
      default: begin // ST_SCAN
        if (!enable) begin
          state_d = ST_IDLE; // word in flight still completes
        end else if (can_issue) begin
          if (ch_q == CH_REF) begin
            issue               = 1'b1;
            word_d.ctrl.cmd     = CMD_INT_REF;
            word_d.ctrl.setting = INT_REF_SETTING;
            ch_d                = CH_A;
          end else if (ch_q != CH_A || !pause) begin // pause only holds before A
            issue             = 1'b1;
            fast_step         = (ch_q == CH_A);
            word_d.chan.cmd   = CMD_WRITE_UPDATE;
            word_d.chan.addr  = ch_q;
            word_d.chan.level = chan_level;
            ch_d              = ch_q + 3'd1;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state_q <= ST_IDLE;
      ch_q    <= CH_A;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ch_q    <= ch_d;
      start_q <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) word_q <= word_d;
    if (fast_step) begin
      lvl_b_q <= level_b; // pre-step values, so B and D mirror the A word
      lvl_c_q <= level_c;
      lvl_d_q <= level_d;
    end
  end

  // sticky flags, a set beats a clear
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      new_line_q  <= 1'b0;
      new_frame_q <= 1'b0;
    end else begin
      if (line_wrap && !frame_wrap) new_line_q <= 1'b1;
      else if (new_line_fifo_done)  new_line_q <= 1'b0;
      if (frame_wrap)               new_frame_q <= 1'b1;
      else if (new_frame_fifo_done) new_frame_q <= 1'b0;
    end
  end

  assign spi_start = start_q;
  assign spi_word  = word_q;
  assign new_line  = new_line_q;
  assign new_frame = new_frame_q;

  // the spi master must be idle at a start and answer with busy
  a_start_idle: assert property (@(posedge clk) disable iff (mems_soft_reset)
    spi_start |-> !spi_busy ##1 spi_busy);

endmodule

`default_nettype wire

// File: source/dac_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module dac_spi_master (
  input  logic        clk,
  input  logic        mems_soft_reset,
  input  logic        start,
  input  logic [23:0] word,
  output logic        sclk,
  output logic        mosi,
  output logic        cs_n,
  output logic        busy
);
  import mems_scan_pkg::*;

  logic [23:0] shift_q;
  logic [7:0]  div_cnt_q;
  logic [5:0]  half_cnt_q;
  logic        half_done;

  assign half_done = (div_cnt_q == SPI_DIV - 8'd1);

  // mode 1 framing, sclk idles low and mosi moves on the rising edge
  // so the dac samples each bit on the falling edge
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      sclk       <= 1'b0;
      mosi       <= 1'b0;
      cs_n       <= 1'b1;
      busy       <= 1'b0;
      div_cnt_q  <= 8'd0;
      half_cnt_q <= 6'd0;
    end else if (!busy) begin
      if (start) begin
        busy       <= 1'b1;
        cs_n       <= 1'b0;
        div_cnt_q  <= 8'd0;
        half_cnt_q <= 6'd0;
      end
    end else if (cs_n) begin
      busy <= 1'b0; // one tail cycle after cs_n rises
    end else if (half_done) begin
      div_cnt_q <= 8'd0;
      sclk      <= ~sclk;
      if (!sclk) begin
        mosi <= shift_q[23]; // msb first
      end
      if (half_cnt_q == SPI_LAST_HALF) begin
        cs_n       <= 1'b1; // last falling edge closes the frame
        half_cnt_q <= 6'd0;
      end else begin
        half_cnt_q <= half_cnt_q + 6'd1;
      end
    end else begin
      div_cnt_q <= div_cnt_q + 8'd1;
    end
  end

  // payload shifter
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shift_q <= word;
    end else if (busy && !cs_n && half_done && !sclk) begin
      shift_q <= {shift_q[22:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: source/mems_scan_top.sv
`timescale 1ns/1ps
`default_nettype none

module mems_scan_top (
  input  logic        clk,
  input  logic        mems_soft_reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        sclk,
  output logic        mosi,
  output logic        cs_n,
  input  logic        new_line_fifo_done,
  input  logic        new_frame_fifo_done,
  output logic        new_line,
  output logic        new_frame
);

  logic        enable, pause;
  logic [7:0]  fast_down, fast_up;
  logic [7:0]  slow_down, slow_up;
  logic [7:0]  level_a, level_b, level_c, level_d;
  logic        fast_step, line_wrap, frame_wrap;
  logic        spi_start, spi_busy;
  logic [23:0] spi_word;

  mems_apb_regs mems_apb_regs_inst (
    .clk(clk), .mems_soft_reset(mems_soft_reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .new_line(new_line), .new_frame(new_frame), .spi_busy(spi_busy),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .enable(enable), .pause(pause),
    .fast_down(fast_down), .fast_up(fast_up),
    .slow_down(slow_down), .slow_up(slow_up)
  );

  fast_axis_ramp fast_axis_ramp_inst (
    .clk(clk), .mems_soft_reset(mems_soft_reset), .step(fast_step),
    .down_limit(fast_down), .up_limit(fast_up),
    .level_a(level_a), .level_b(level_b), .line_wrap(line_wrap)
  );

  // slow axis advances once per line
  slow_axis_ramp slow_axis_ramp_inst (
    .clk(clk), .mems_soft_reset(mems_soft_reset), .step(line_wrap),
    .down_limit(slow_down), .up_limit(slow_up),
    .level_c(level_c), .level_d(level_d), .frame_wrap(frame_wrap)
  );

  dac_frame_sequencer dac_frame_sequencer_inst (
    .clk(clk), .mems_soft_reset(mems_soft_reset),
    .enable(enable), .pause(pause), .spi_busy(spi_busy),
    .level_a(level_a), .level_b(level_b), .level_c(level_c), .level_d(level_d),
    .line_wrap(line_wrap), .frame_wrap(frame_wrap),
    .new_line_fifo_done(new_line_fifo_done), .new_frame_fifo_done(new_frame_fifo_done),
    .fast_step(fast_step), .spi_start(spi_start), .spi_word(spi_word),
    .new_line(new_line), .new_frame(new_frame)
  );

  dac_spi_master dac_spi_master_inst (
    .clk(clk), .mems_soft_reset(mems_soft_reset),
    .start(spi_start), .word(spi_word),
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .busy(spi_busy)
  );

endmodule

`default_nettype wire

// File: tests/scan_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module scan_monitor (
  input  wire logic        clk,
  input  wire logic        mems_soft_reset,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [7:0]  paddr,
  input  wire logic [31:0] pwdata,
  input  wire logic [31:0] prdata,
  input  wire logic        pready,
  input  wire logic        pslverr,
  input  wire logic        sclk,
  input  wire logic        mosi,
  input  wire logic        cs_n,
  input  wire logic        new_line,
  input  wire logic        new_frame,
  input  wire logic        new_line_fifo_done,
  input  wire logic        new_frame_fifo_done,
  input  wire logic        end_check,
  output int               error_count,
  output int               word_count,
  output int               ref_count
);

  // expected word kinds, in the order the sequencer sends them
  localparam int K_SRST = 0;
  localparam int K_LDAC = 1;
  localparam int K_A    = 2;
  localparam int K_B    = 3;
  localparam int K_C    = 4;
  localparam int K_D    = 5;
  localparam int K_REF  = 6;

  // register model snooped off apb writes
  logic        ctrl_en, ctrl_pause;
  logic [7:0]  fd, fu, sd, su;
  logic        p0, p1, p2; // pause over the last three cycles

  // ramp model
  logic [7:0]  a_m, c_m;
  logic [7:0]  snap_b, snap_c, snap_d;
  logic        wrap, fwrap;

  int          kind;
  logic [23:0] exp_word;
  logic [23:0] shift;
  int          nbits;
  logic        in_word;
  logic        sclk_p, cs_p;

  // flag history and rise bookkeeping
  logic        nl_p1, nl_p2, nf_p1, nf_p2;
  logic        nl_done_q, nf_done_q;
  int          line_rises, frame_rises, line_expl, frame_expl;
  logic        end_done;

  logic        mapped, exp_err;
  logic [31:0] exp_rd;

  function automatic logic [23:0] chan_word(input logic [2:0] addr, input logic [7:0] lvl);
    return {2'b00, 3'b011, addr, lvl, 8'h00}; // write and update
  endfunction

  function automatic string kind_name(input int k);
    case (k)
      K_SRST:  return "soft reset";
      K_LDAC:  return "ldac setup";
      K_A:     return "channel A";
      K_B:     return "channel B";
      K_C:     return "channel C";
      K_D:     return "channel D";
      default: return "int ref";
    endcase
  endfunction

  task automatic mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic failure(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  initial begin
    error_count = 0;
    word_count  = 0;
    ref_count   = 0;
    end_done    = 1'b0;
  end

  // everything is sampled mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (mems_soft_reset) begin
      ctrl_en    = 1'b0;
      ctrl_pause = 1'b0;
      fd = 8'd34;
      fu = 8'd154;
      sd = 8'd34;
      su = 8'd154;
      a_m = 8'd34;
      c_m = 8'd34;
      p0 = 1'b0;
      p1 = 1'b0;
      p2 = 1'b0;
      kind    = K_SRST;
      in_word = 1'b0;
      nbits   = 0;
      shift   = '0;
      sclk_p  = sclk;
      cs_p    = 1'b1;
      nl_p1 = 1'b0;
      nl_p2 = 1'b0;
      nf_p1 = 1'b0;
      nf_p2 = 1'b0;
      nl_done_q = 1'b0;
      nf_done_q = 1'b0;
      line_rises  = 0;
      frame_rises = 0;
      line_expl   = 0;
      frame_expl  = 0;
      if (pslverr || !cs_n || sclk) failure("outputs not idle during reset");
    end else begin
      p2 = p1;
      p1 = p0;
      p0 = ctrl_pause;

      // apb access phase
      if (psel && penable) begin
        if (pready !== 1'b1) begin
          mismatch($sformatf("pready %0b in access phase at offset 0x%02h", pready, paddr));
        end
        mapped  = paddr inside {8'h00, 8'h04, 8'h08, 8'h0C};
        exp_err = !mapped || (pwrite && paddr == 8'h0C); // status is read only
        if (pslverr !== exp_err) begin
          mismatch($sformatf("pslverr %0b on %s at offset 0x%02h", pslverr,
                             pwrite ? "write" : "read", paddr));
        end
        if (!pwrite) begin
          case (paddr)
            8'h00:   exp_rd = {30'd0, ctrl_pause, ctrl_en};
            8'h04:   exp_rd = {16'd0, fu, fd};
            8'h08:   exp_rd = {16'd0, su, sd};
            8'h0C:   exp_rd = {29'd0, !cs_n || !cs_p, new_frame, new_line}; // busy outlasts cs_n
            default: exp_rd = 32'd0;
          endcase
          if (prdata !== exp_rd) begin
            mismatch($sformatf("read 0x%02h got 0x%08h expected 0x%08h", paddr, prdata, exp_rd));
          end
        end else if (!exp_err) begin
          case (paddr)
            8'h00: begin
              if (pwdata[0] && !ctrl_en) kind = K_SRST; // fresh start sequence
              ctrl_en    = pwdata[0];
              ctrl_pause = pwdata[1];
            end
            8'h04: begin
              fd = pwdata[7:0];
              fu = pwdata[15:8];
            end
            default: begin
              sd = pwdata[7:0];
              su = pwdata[15:8];
            end
          endcase
        end
      end

      // a done pulse clears its flag one cycle later
      if (nl_done_q && new_line) failure("new_line still set after new_line_fifo_done");
      if (nf_done_q && new_frame) failure("new_frame still set after new_frame_fifo_done");

      // spi bits are stable at the falling sclk edge
      if (in_word && sclk_p && !sclk) begin
        shift = {shift[22:0], mosi};
        nbits++;
      end

      if (cs_p && !cs_n) begin
        in_word = 1'b1;
        nbits   = 0;
        case (kind)
          K_SRST: exp_word = {2'b00, 3'b101, 3'b000, 16'h0001};
          K_LDAC: exp_word = {2'b00, 3'b110, 3'b000, 16'h000F};
          K_A: begin
            if (p2) failure("A word started while pause is set");
            wrap  = a_m > fu;
            fwrap = wrap && (c_m > su);
            exp_word = chan_word(3'd0, a_m);
            snap_b = fd + fu - a_m;
            snap_c = c_m;
            snap_d = sd + su - c_m;
            // flag was set the cycle before cs_n fell
            if (wrap && !fwrap) begin
              if (!nl_p1) failure("new_line not set at a line wrap");
              else if (!nl_p2) line_expl++;
            end else if (nl_p1 && !nl_p2) begin
              failure("new_line rose without a plain line wrap");
            end
            if (fwrap) begin
              if (!nf_p1) failure("new_frame not set at a frame wrap");
              else if (!nf_p2) frame_expl++;
            end else if (nf_p1 && !nf_p2) begin
              failure("new_frame rose without a frame wrap");
            end
            if (wrap) begin
              a_m = fd;
              c_m = fwrap ? sd : c_m + 8'd1;
            end else begin
              a_m = a_m + 8'd1;
            end
          end
          K_B:     exp_word = chan_word(3'd1, snap_b);
          K_C:     exp_word = chan_word(3'd2, snap_c);
          K_D:     exp_word = chan_word(3'd3, snap_d);
          default: exp_word = {2'b00, 3'b111, 3'b000, 16'h0001};
        endcase
      end

      if (in_word && !cs_p && cs_n) begin
        in_word = 1'b0;
        word_count++;
        if (nbits != 24) begin
          failure($sformatf("%s word carried %0d bits instead of 24", kind_name(kind), nbits));
        end else if (shift !== exp_word) begin
          mismatch($sformatf("%s word got 0x%06h expected 0x%06h", kind_name(kind),
                             shift, exp_word));
        end
        if (kind == K_REF) begin
          ref_count++;
          kind = K_A;
        end else begin
          kind = kind + 1;
        end
      end

      if (new_line && !nl_p1) line_rises++;
      if (new_frame && !nf_p1) frame_rises++;
      nl_p2 = nl_p1;
      nl_p1 = new_line;
      nf_p2 = nf_p1;
      nf_p1 = new_frame;
      nl_done_q = new_line_fifo_done;
      nf_done_q = new_frame_fifo_done;
      sclk_p = sclk;
      cs_p   = cs_n;

      // every flag rise must belong to a predicted wrap
      if (end_check && !end_done) begin
        end_done = 1'b1;
        if (line_rises != line_expl) begin
          failure($sformatf("new_line rose %0d times, %0d wraps explain it",
                            line_rises, line_expl));
        end
        if (frame_rises != frame_expl) begin
          failure($sformatf("new_frame rose %0d times, %0d wraps explain it",
                            frame_rises, frame_expl));
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_mems_scan.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mems_scan;
  import mems_scan_pkg::*;

  localparam int NUM_ROWS = 5;

  logic        clk;
  logic        mems_soft_reset;
  logic        psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready, pslverr;
  logic        sclk, mosi, cs_n;
  logic        new_line_fifo_done, new_frame_fifo_done;
  logic        new_line, new_frame;
  logic        end_check;
  logic        done_enable;
  int          error_count, word_count, ref_count;
  int          cycles;
  int          cycle_limit;
  int          total_points;
  logic [31:0] lfsr_state;
  logic [31:0] rdata;

  // limits as written to the register, {up, down}
  logic [15:0] tab_fast[NUM_ROWS]   = '{16'h9A22, 16'h0E0A, 16'h1614, 16'h0605, 16'h3532};
  logic [15:0] tab_slow[NUM_ROWS]   = '{16'h9A22, 16'h0503, 16'h0807, 16'h0201, 16'h0A09};
  logic        tab_pause[NUM_ROWS]  = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
  int          tab_points[NUM_ROWS] = '{6, 40, 30, 20, 25};
  logic        tab_done[NUM_ROWS]   = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1}; // row 3 leaves flags set

  mems_scan_top mems_scan_top_inst (
    .clk(clk), .mems_soft_reset(mems_soft_reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
    .new_line_fifo_done(new_line_fifo_done), .new_frame_fifo_done(new_frame_fifo_done),
    .new_line(new_line), .new_frame(new_frame)
  );

  scan_monitor scan_monitor_inst (
    .clk(clk), .mems_soft_reset(mems_soft_reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
    .new_line(new_line), .new_frame(new_frame),
    .new_line_fifo_done(new_line_fifo_done), .new_frame_fifo_done(new_frame_fifo_done),
    .end_check(end_check),
    .error_count(error_count), .word_count(word_count), .ref_count(ref_count)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_next_bit());
    end
    return v;
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_spi_idle();
    logic [31:0] st;
    repeat (4) @(posedge clk); // a start may still be in flight
    apb_read(ADDR_STATUS, st);
    while (st[2]) begin
      apb_read(ADDR_STATUS, st);
    end
  endtask

  task automatic wait_refs(input int n);
    while (ref_count < n) @(posedge clk);
  endtask

  task automatic run_row(input int r);
    int          target;
    int          mid;
    int          gap;
    logic [31:0] st;
    apb_write(ADDR_CTRL, 32'd0);
    wait_spi_idle();
    apb_write(ADDR_FAST_LIM, {16'd0, tab_fast[r]});
    apb_write(ADDR_SLOW_LIM, {16'd0, tab_slow[r]});
    done_enable = tab_done[r];
    mid    = ref_count + tab_points[r] / 2;
    target = ref_count + tab_points[r];
    apb_write(ADDR_CTRL, 32'd1);
    if (tab_pause[r]) begin
      wait_refs(mid);
      apb_write(ADDR_CTRL, 32'd3); // enable plus pause
      wait_refs(mid + 1); // the point already begun still completes
      gap = 32 + rand_bits(6);
      repeat (gap) @(posedge clk);
      apb_write(ADDR_CTRL, 32'd1);
    end
    wait_refs(target);
    apb_read(ADDR_STATUS, st);
    $display("row %0d finished: fast 0x%04h slow 0x%04h pause %0b points %0d, errors %0d",
             r, tab_fast[r], tab_slow[r], tab_pause[r], tab_points[r], error_count);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // done pulses follow a flag after a short random delay
  initial begin : line_done_driver
    int d;
    forever begin
      @(negedge clk);
      if (new_line && done_enable && !new_line_fifo_done) begin
        d = 1 + rand_bits(3);
        repeat (d) @(posedge clk);
        new_line_fifo_done <= 1'b1;
        @(posedge clk);
        new_line_fifo_done <= 1'b0;
      end
    end
  end

  initial begin : frame_done_driver
    int d;
    forever begin
      @(negedge clk);
      if (new_frame && done_enable && !new_frame_fifo_done) begin
        d = 1 + rand_bits(3);
        repeat (d) @(posedge clk);
        new_frame_fifo_done <= 1'b1;
        @(posedge clk);
        new_frame_fifo_done <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    mems_soft_reset     = 1'b1;
    psel                = 1'b0;
    penable             = 1'b0;
    pwrite              = 1'b0;
    paddr               = 8'h00;
    pwdata              = 32'd0;
    new_line_fifo_done  = 1'b0;
    new_frame_fifo_done = 1'b0;
    end_check           = 1'b0;
    done_enable         = 1'b0;
    cycles              = 0;
    lfsr_state          = 32'h3d8e;
    total_points = 0;
    for (int r = 0; r < NUM_ROWS; r++) total_points += tab_points[r];
    // five words per point at the spi bit rate, doubled for overhead
    cycle_limit = total_points * 5 * 24 * 2 * int'(SPI_DIV) * 2 + NUM_ROWS * 3000 + 5000;

    repeat (5) @(posedge clk);
    mems_soft_reset <= 1'b0;
    @(posedge clk);

    // reset values and error responses
    apb_read(ADDR_FAST_LIM, rdata);
    apb_read(ADDR_SLOW_LIM, rdata);
    apb_read(8'h10, rdata);
    apb_write(ADDR_STATUS, 32'd7);

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end

    end_check <= 1'b1;
    repeat (3) @(posedge clk);
    $display("rows %0d, words checked %0d, points %0d, errors %0d",
             NUM_ROWS, word_count, ref_count, error_count);
    if (error_count == 0 && word_count > 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
source/mems_scan_pkg.sv
source/mems_apb_regs.sv
source/fast_axis_ramp.sv
source/slow_axis_ramp.sv
source/dac_frame_sequencer.sv
source/dac_spi_master.sv
source/mems_scan_top.sv
tests/scan_monitor.sv
tests/tb_mems_scan.sv

// File: run.sh
#!/bin/sh
# build and run the MEMS scan testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mems_scan -f files.f

out=$(./obj_dir/Vtb_mems_scan)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi
